// ==== verification/tdc_golden.txt ====
# S run_length en meas_a meas_b finc fdec tready (one entry per run of equal cycles)
# E header period_hi period_lo first_hi first_lo last_hi last_lo tlast_bits
S 5 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 4 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 9 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 17 1 0 0 0 0 1
S 5 1 0 0 0 1 1
S 17 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 9 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 11 1 0 0 0 0 1
S 1 1 0 0 1 0 1
S 1 1 1 0 1 0 1
S 3 1 0 0 1 0 1
S 13 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 17 1 0 0 0 0 1
S 5 1 0 0 1 1 1
S 2 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 4 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 9 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 19 1 0 0 0 0 1
S 4 1 0 0 0 0 0
S 6 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 9 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 18 1 0 0 0 0 1
S 6 1 0 0 0 0 0
S 1 1 0 1 0 0 0
S 9 1 0 0 0 0 0
S 1 1 1 0 0 0 0
S 24 1 0 0 0 0 0
S 1 1 1 0 0 0 0
S 9 1 0 0 0 0 0
S 1 1 0 1 0 0 0
S 39 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 9 1 0 0 0 0 1
S 21 0 0 0 0 0 1
S 9 1 0 0 0 0 1
S 1 1 0 1 0 0 1
S 39 1 0 0 0 0 1
S 1 1 1 0 0 0 1
S 49 1 0 0 0 0 1
E 40 00 28 00 06 00 15 0000001
E C0 00 28 00 0B 00 0B 0000001
E 00 00 2C FF FF FF FF 0000001
E C0 00 2C 00 15 00 1F 0000001
E 40 00 24 00 00 00 11 0000001
E 80 00 24 FF FF FF FF 0000001
E 40 00 24 00 0B 00 0B 0000001
E C0 00 24 00 06 00 15 0000001
E 40 00 28 00 0F 00 0F 0000001
E C0 00 28 00 19 00 19 0000001
E 40 00 28 00 14 00 14 0000001
E C0 00 28 00 0F 00 0F 0000001
E 40 00 28 00 05 00 05 0000001
E 80 00 28 FF FF FF FF 0000001
E 40 00 28 00 0F 00 0F 0000001

// ==== files.f ====
+incdir+common
common/tdc_pkg.sv
common/tdc_record_if.sv
hdl/gate_divider.sv
tdc/tdc_channel.sv
tdc/record_arbiter.sv
hdl/byte_serializer.sv
hdl/tdc_top.sv
verification/tdc_props.sv
verification/tdc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TDC testbench with Verilator from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tdc_tb \
    -f files.f \
    -o tdc_sim

./obj_dir/tdc_sim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"

// ==== verification/tdc_tb.sv ====
// Self-checking TDC testbench; reads verification/tdc_golden.txt relative to the project root
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_tb;
    import tdc_pkg::*;

    localparam int CLK_NS = 8;

    logic       clk_gate;
    logic       rst_gate;
    logic       en;
    logic       meas_a;
    logic       meas_b;
    logic       gate_finc;
    logic       gate_fdec;
    logic       tready;
    logic [7:0] tdata;
    logic       tkeep;
    logic       tvalid;
    logic       tlast;

    // Golden stimulus with one entry per run of equal cycles
    int          s_len_q [$];
    logic [5:0]  s_val_q [$];
    // Expected transfers in send order
    logic [7:0]  e_data_q [$];
    logic        e_last_q [$];
    int          total_cycles;
    logic        loaded;

    // Progress and error counts
    int          seen_bytes;
    int          seen_recs;
    int          rec_pos;
    int          mismatch_cnt;
    int          other_cnt;
    tdc_record_u got_rec;
    tdc_record_u exp_rec;

    // ====================
    // Clock and DUT
    // ====================

    always #(CLK_NS / 2) clk_gate = ~clk_gate;

    tdc_top dut_i (
        .i_clk_gate  (clk_gate),
        .i_rst_gate  (rst_gate),
        .i_en        (en),
        .i_meas_a    (meas_a),
        .i_meas_b    (meas_b),
        .i_gate_finc (gate_finc),
        .i_gate_fdec (gate_fdec),
        .i_tready    (tready),
        .o_tdata     (tdata),
        .o_tkeep     (tkeep),
        .o_tvalid    (tvalid),
        .o_tlast     (tlast)
    );

    // ====================
    // Golden file
    // ====================

    // S lines hold run length, en, meas_a, meas_b, finc, fdec and tready
    // E lines hold seven bytes in send order and then the tlast bits
    task automatic load_golden(output logic ok);
        int               fd;
        int               code;
        int               n;
        int               k;
        int               v [6];
        logic [7:0]       tag;
        logic [7:0]       byte_v;
        logic [6:0]       last_mask;
        logic [8*256-1:0] rest;
        total_cycles = 0;
        fd = $fopen("verification/tdc_golden.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "S") begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d",
                                   n, v[0], v[1], v[2], v[3], v[4], v[5]);
                    s_len_q.push_back(n);
                    s_val_q.push_back({v[0][0], v[1][0], v[2][0], v[3][0], v[4][0], v[5][0]});
                    total_cycles += n;
                end else if (tag == "E") begin
                    for (k = 0; k < `TDC_REC_BYTES; k++) begin
                        code = $fscanf(fd, "%h", byte_v);
                        e_data_q.push_back(byte_v);
                    end
                    code = $fscanf(fd, "%b", last_mask);
                    // Leftmost digit belongs to the header byte
                    for (k = 0; k < `TDC_REC_BYTES; k++) begin
                        e_last_q.push_back(last_mask[6]);
                        last_mask = last_mask << 1;
                    end
                end else begin
                    code = $fgets(rest, fd);
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // Compare tasks
    // ====================

    task automatic check_byte(input logic [7:0] got_data, input logic [7:0] exp_data,
                              input logic got_last, input logic exp_last,
                              input logic got_keep);
        if (got_data !== exp_data) begin
            $display("MISMATCH at %0t ns: byte %0d tdata %h, expected %h",
                     $time, seen_bytes, got_data, exp_data);
            mismatch_cnt++;
        end
        if (got_last !== exp_last) begin
            $display("MISMATCH at %0t ns: byte %0d tlast %b, expected %b",
                     $time, seen_bytes, got_last, exp_last);
            mismatch_cnt++;
        end
        // Every byte of a record is a full byte
        if (got_keep !== 1'b1) begin
            $display("MISMATCH at %0t ns: byte %0d tkeep %b, expected 1",
                     $time, seen_bytes, got_keep);
            mismatch_cnt++;
        end
    endtask

    task automatic check_record(input tdc_record_u got, input tdc_record_u exp);
        if (got.f.chan_id !== exp.f.chan_id || got.f.valid !== exp.f.valid) begin
            $display("MISMATCH at %0t ns: record %0d header chan %b valid %b, expected %b %b",
                     $time, seen_recs, got.f.chan_id, got.f.valid, exp.f.chan_id, exp.f.valid);
            mismatch_cnt++;
        end
        if (got.f.period !== exp.f.period) begin
            $display("MISMATCH at %0t ns: record %0d period %0d, expected %0d",
                     $time, seen_recs, got.f.period, exp.f.period);
            mismatch_cnt++;
        end
        if (got.f.first !== exp.f.first || got.f.last !== exp.f.last) begin
            $display("MISMATCH at %0t ns: record %0d first/last %h/%h, expected %h/%h",
                     $time, seen_recs, got.f.first, got.f.last, exp.f.first, exp.f.last);
            mismatch_cnt++;
        end
    endtask

    // ====================
    // Stream monitor
    // ====================

    task automatic take_byte(input logic [7:0] data, input logic last, input logic keep);
        logic [7:0] exp_d;
        logic       exp_l;
        if (e_data_q.size() == 0) begin
            $display("Unexpected transfer at %0t ns: byte %h after the golden data ran out",
                     $time, data);
            other_cnt++;
        end else begin
            exp_d = e_data_q.pop_front();
            exp_l = e_last_q.pop_front();
            check_byte(data, exp_d, last, exp_l, keep);
            // Shifted in so that the header ends up in the top byte
            got_rec.b = {got_rec.b[`TDC_REC_BYTES-2:0], data};
            exp_rec.b = {exp_rec.b[`TDC_REC_BYTES-2:0], exp_d};
            rec_pos++;
            if (rec_pos == `TDC_REC_BYTES) begin
                check_record(got_rec, exp_rec);
                rec_pos = 0;
                seen_recs++;
            end
        end
        seen_bytes++;
    endtask

    // Sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk_gate) begin
        if (!rst_gate && tvalid && tready) begin
            take_byte(tdata, tlast, tkeep);
        end
    end

    task automatic drive_inputs(input logic [5:0] val);
        {en, meas_a, meas_b, gate_finc, gate_fdec, tready} = val;
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int         n;
        logic [5:0] val;
        logic       load_ok;
        clk_gate     = 1'b0;
        rst_gate     = 1'b1;
        drive_inputs(6'b0);
        loaded       = 1'b0;
        seen_bytes   = 0;
        seen_recs    = 0;
        rec_pos      = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        load_golden(load_ok);
        if (!load_ok) begin
            $display("Could not open verification/tdc_golden.txt");
            $display("Errors found");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk_gate);
            #1;
            rst_gate = 1'b0;
            // First entry lands with the reset release and one follows per cycle
            while (s_len_q.size() > 0) begin
                n   = s_len_q.pop_front();
                val = s_val_q.pop_front();
                repeat (n) begin
                    drive_inputs(val);
                    @(posedge clk_gate);
                    #1;
                end
            end
            // Drain whatever the stream still owes
            while (e_data_q.size() != 0) begin
                @(posedge clk_gate);
            end
            @(posedge clk_gate);
            $display("Checked %0d bytes, %0d records; mismatches %0d, other errors %0d",
                     seen_bytes, seen_recs, mismatch_cnt, other_cnt);
            if (mismatch_cnt == 0 && other_cnt == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    // Stimulus length plus reset plus drain margin
    initial begin
        wait (loaded);
        #((total_cycles + 2) * CLK_NS + 2000);
        $display("Timeout: %0d expected bytes were never transferred", e_data_q.size());
        $display("Errors found");
        $finish;
    end

endmodule

// ==== verification/tdc_props.sv ====
// Stream and record bus properties bound into tdc_top; all are off while reset is high
`timescale 1ns/1ps

module tdc_props (
    input logic                 i_clk_gate,
    input logic                 i_rst_gate,
    input logic                 i_tready,
    input logic [7:0]           i_tdata,
    input logic                 i_tvalid,
    input logic                 i_tlast,
    input logic                 i_a_valid,
    input logic                 i_b_valid,
    input logic                 i_m_valid,
    input logic                 i_m_ready,
    input tdc_pkg::tdc_record_u i_m_record
);

    // ====================
    // Output stream
    // ====================

    // Offered byte stays until taken
    tvalid_hold_a: assert property (@(posedge i_clk_gate) disable iff (i_rst_gate)
        i_tvalid && !i_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tlast))
        else $error("stream byte changed or vanished under back-pressure");

    // Serializer needs one idle cycle before the next record starts
    last_gap_a: assert property (@(posedge i_clk_gate) disable iff (i_rst_gate)
        i_tvalid && i_tready && i_tlast |=> !i_tvalid)
        else $error("stream stayed valid right after the last byte");

    // ====================
    // Arbiter grant
    // ====================

    // A channel left waiting at a transfer is offered next
    turn_a: assert property (@(posedge i_clk_gate) disable iff (i_rst_gate)
        i_m_valid && i_m_ready && i_a_valid && i_b_valid
        |=> i_m_valid && (i_m_record.f.chan_id != $past(i_m_record.f.chan_id)))
        else $error("arbiter did not pass the turn to the waiting channel");

    // Merged bus holds its record until the serializer takes it
    rec_hold_a: assert property (@(posedge i_clk_gate) disable iff (i_rst_gate)
        i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_record))
        else $error("merged record changed before its transfer");

endmodule

bind tdc_top tdc_props props_i (
    .i_clk_gate (i_clk_gate),
    .i_rst_gate (i_rst_gate),
    .i_tready   (i_tready),
    .i_tdata    (o_tdata),
    .i_tvalid   (o_tvalid),
    .i_tlast    (o_tlast),
    .i_a_valid  (rec_a.valid),
    .i_b_valid  (rec_b.valid),
    .i_m_valid  (rec_m.valid),
    .i_m_ready  (rec_m.ready),
    .i_m_record (rec_m.record)
);

// ==== hdl/tdc_top.sv ====
// Two-channel TDC on clk_gate only; meas inputs must already be synchronous, no CDC inside
`timescale 1ns/1ps

module tdc_top (
    input  logic       i_clk_gate,
    input  logic       i_rst_gate,
    input  logic       i_en,
    input  logic       i_meas_a,
    input  logic       i_meas_b,
    input  logic       i_gate_finc,
    input  logic       i_gate_fdec,
    input  logic       i_tready,
    output logic [7:0] o_tdata,
    output logic       o_tkeep,
    output logic       o_tvalid,
    output logic       o_tlast
);
    import tdc_pkg::*;

    // Window boundary shared by both channels
    logic gate_tick;

    // ====================
    // Record buses
    // ====================

    // Channel A to arbiter
    tdc_record_if rec_a ();
    // Channel B to arbiter
    tdc_record_if rec_b ();
    // Arbiter to serializer
    tdc_record_if rec_m ();

    // ====================
    // Gate reference
    // ====================

    gate_divider u_gate_div (
        .i_clk_gate (i_clk_gate),
        .i_rst_gate (i_rst_gate),
        .i_finc     (i_gate_finc),
        .i_fdec     (i_gate_fdec),
        .o_tick     (gate_tick)
    );

    // ====================
    // Channels
    // ====================

    tdc_channel #(
        .P_CHAN (CHAN_A)
    ) u_chan_a (
        .i_clk_gate (i_clk_gate),
        .i_rst_gate (i_rst_gate),
        .i_en       (i_en),
        .i_tick     (gate_tick),
        .i_meas     (i_meas_a),
        .rec        (rec_a.src)
    );

    tdc_channel #(
        .P_CHAN (CHAN_B)
    ) u_chan_b (
        .i_clk_gate (i_clk_gate),
        .i_rst_gate (i_rst_gate),
        .i_en       (i_en),
        .i_tick     (gate_tick),
        .i_meas     (i_meas_b),
        .rec        (rec_b.src)
    );

    // Both channels close on the same tick, so collisions are the norm
    record_arbiter u_arb (
        .i_clk_gate (i_clk_gate),
        .i_rst_gate (i_rst_gate),
        .req_a      (rec_a.dst),
        .req_b      (rec_b.dst),
        .grant_out  (rec_m.src)
    );

    // ====================
    // Output stream
    // ====================

    byte_serializer u_ser (
        .i_clk_gate (i_clk_gate),
        .i_rst_gate (i_rst_gate),
        .rec        (rec_m.dst),
        .i_tready   (i_tready),
        .o_tdata    (o_tdata),
        .o_tkeep    (o_tkeep),
        .o_tvalid   (o_tvalid),
        .o_tlast    (o_tlast)
    );

endmodule

// ==== hdl/byte_serializer.sv ====
// Record to byte stream, header byte first and counts MSB first; keep is constant 1
`timescale 1ns/1ps
`include "tdc_settings.svh"

module byte_serializer (
    input  logic       i_clk_gate,
    input  logic       i_rst_gate,
    tdc_record_if.dst  rec,
    input  logic       i_tready,
    output logic [7:0] o_tdata,
    output logic       o_tkeep,
    output logic       o_tvalid,
    output logic       o_tlast
);
    import tdc_pkg::*;

    localparam int unsigned IDX_W = $clog2(`TDC_REC_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`TDC_REC_BYTES - 1);

    // Record in flight
    logic             busy_q;
    // Byte position, 0 is the header
    logic [IDX_W-1:0] idx_q;
    tdc_record_u      word_q;
    tdc_record_u      load_word;
    logic             accept;
    logic             beat;

    // ====================
    // Record intake
    // ====================

    // Only an idle serializer takes a record
    assign rec.ready = ~busy_q;
    assign accept    = rec.valid & ~busy_q;

    // No edge in the window, first and last go out as 0xFF
    always_comb begin
        load_word = rec.record;
        if (!load_word.f.valid) begin
            load_word.f.first = '1;
            load_word.f.last  = '1;
        end
    end

    always_ff @(posedge i_clk_gate) begin
        if (accept) begin
            word_q <= load_word;
        end
    end

    // ====================
    // Byte stepping
    // ====================

    // Byte handed over this cycle
    assign beat = busy_q & i_tready;

    // Idle again the cycle after the last byte
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (beat) begin
            if (idx_q == LAST_IDX) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // ====================
    // Stream outputs
    // ====================

    // Header sits at the top byte of the union
    assign o_tdata  = word_q.b[LAST_IDX - idx_q];
    assign o_tvalid = busy_q;
    // Held with the byte under back-pressure
    assign o_tlast  = busy_q & (idx_q == LAST_IDX);
    assign o_tkeep  = 1'b1;

endmodule

// ==== tdc/record_arbiter.sv ====
// Round-robin merge of two record buses; sources must hold valid until they are served
`timescale 1ns/1ps

module record_arbiter (
    input  logic      i_clk_gate,
    input  logic      i_rst_gate,
    tdc_record_if.dst req_a,
    tdc_record_if.dst req_b,
    tdc_record_if.src grant_out
);
    import tdc_pkg::*;

    // Last served channel, B after reset so that A goes first
    chan_id_t owner_q;
    // Offered record not yet taken
    logic     hold_q;
    chan_id_t sel;

    // ====================
    // Grant
    // ====================

    always_comb begin
        if (hold_q) begin
            // Locked until the waiting record transfers
            sel = owner_q;
        end else if (req_a.valid && req_b.valid) begin
            // Collision, the other channel's turn
            sel = (owner_q == CHAN_A) ? CHAN_B : CHAN_A;
        end else if (req_b.valid) begin
            sel = CHAN_B;
        end else begin
            sel = CHAN_A;
        end
    end

    // Owner follows the offered grant; it only differs from the winner
    // of the last transfer while the lock is off
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            owner_q <= CHAN_B;
            hold_q  <= 1'b0;
        end else if (grant_out.valid) begin
            owner_q <= sel;
            hold_q  <= ~grant_out.ready;
        end
    end

    // ====================
    // Data path
    // ====================

    // Pure mux, no register on the record
    assign grant_out.valid  = (sel == CHAN_B) ? req_b.valid : req_a.valid;
    assign grant_out.record = (sel == CHAN_B) ? req_b.record : req_a.record;

    // Ready only to the granted side
    assign req_a.ready = grant_out.ready & (sel == CHAN_A);
    assign req_b.ready = grant_out.ready & (sel == CHAN_B);

endmodule

// ==== tdc/tdc_channel.sv ====
// One TDC channel; i_meas is assumed synchronous to clk_gate, one record is held at most
`timescale 1ns/1ps
`include "tdc_settings.svh"

module tdc_channel #(
    parameter tdc_pkg::chan_id_t P_CHAN = 1'b0
) (
    input  logic      i_clk_gate,
    input  logic      i_rst_gate,
    input  logic      i_en,
    input  logic      i_tick,
    input  logic      i_meas,
    tdc_record_if.src rec
);
    import tdc_pkg::*;

    // Edge detect
    logic                  meas_q;
    logic                  edge_q;
    // Cycles since the last tick
    logic [`TDC_CTR_W-1:0] win_ctr_q;
    // Edge offsets of the open window
    logic [`TDC_CTR_W-1:0] first_q;
    logic [`TDC_CTR_W-1:0] last_q;
    logic                  seen_q;
    // Set once a full window has started under enable
    logic                  armed_q;
    logic                  load;
    tdc_fields_t           fields;

    // ====================
    // Edge detect
    // ====================

    // Pulse appears the cycle after the input rises
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            meas_q <= 1'b0;
            edge_q <= 1'b0;
        end else begin
            meas_q <= i_meas;
            edge_q <= i_meas & ~meas_q;
        end
    end

    // ====================
    // Window counters
    // ====================

    // Tick cycle is offset 0; at the next tick the count equals the period
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            win_ctr_q <= '0;
        end else if (i_tick) begin
            win_ctr_q <= `TDC_CTR_W'(1);
        end else begin
            win_ctr_q <= win_ctr_q + 1'b1;
        end
    end

    // Edge seen flag of the open window
    // An edge on the tick cycle opens the new window at offset 0
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            seen_q <= 1'b0;
        end else if (i_tick) begin
            seen_q <= edge_q;
        end else if (edge_q) begin
            seen_q <= 1'b1;
        end
    end

    // Offsets, meaningless while seen_q is low
    always_ff @(posedge i_clk_gate) begin
        if (i_tick) begin
            first_q <= '0;
            last_q  <= '0;
        end else if (edge_q) begin
            // First only on the first edge, last on every edge
            if (!seen_q) begin
                first_q <= win_ctr_q;
            end
            last_q <= win_ctr_q;
        end
    end

    // ====================
    // Record build
    // ====================

    // Partial window after reset or enable is not reported
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            armed_q <= 1'b0;
        end else if (!i_en) begin
            armed_q <= 1'b0;
        end else if (i_tick) begin
            armed_q <= 1'b1;
        end
    end

    always_comb begin
        fields.chan_id = P_CHAN;
        fields.valid   = seen_q;
        fields.rsvd    = '0;
        fields.period  = win_ctr_q;
        fields.first   = first_q;
        fields.last    = last_q;
    end

    // Drop the record when the holding register stays full
    assign load = i_tick & i_en & armed_q & ~(rec.valid & ~rec.ready);

    // ====================
    // Holding register
    // ====================

    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            rec.valid <= 1'b0;
        end else if (load) begin
            rec.valid <= 1'b1;
        end else if (rec.ready) begin
            rec.valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk_gate) begin
        if (load) begin
            rec.record.f <= fields;
        end
    end

endmodule

// ==== hdl/gate_divider.sv ====
// Gate tick generator; finc and fdec must already be synchronous to clk_gate, finc wins
`timescale 1ns/1ps
`include "tdc_settings.svh"

module gate_divider (
    input  logic i_clk_gate,
    input  logic i_rst_gate,
    input  logic i_finc,
    input  logic i_fdec,
    output logic o_tick
);

    // Wide enough for the longest (slowed) period
    localparam int unsigned DIV_W = $clog2(`TDC_DIV_GATE + `TDC_DIV_DELTA);

    // Reload values, counted down to zero
    localparam logic [DIV_W-1:0] RELOAD_NOM  = DIV_W'(`TDC_DIV_GATE - 1);
    localparam logic [DIV_W-1:0] RELOAD_SLOW = DIV_W'(`TDC_DIV_GATE - 1 + `TDC_DIV_DELTA);
    localparam logic [DIV_W-1:0] RELOAD_FAST = DIV_W'(`TDC_DIV_GATE - 1 - `TDC_DIV_DELTA);

    logic [DIV_W-1:0] div_ctr_q;
    logic [DIV_W-1:0] reload;

    // ====================
    // Period select
    // ====================

    // Trim only matters on the tick cycle
    always_comb begin
        if (i_finc) begin
            reload = RELOAD_FAST;
        end else if (i_fdec) begin
            reload = RELOAD_SLOW;
        end else begin
            reload = RELOAD_NOM;
        end
    end

    // ====================
    // Down-counter
    // ====================

    // Starts at zero, so the first tick is the first cycle out of reset
    always_ff @(posedge i_clk_gate or posedge i_rst_gate) begin
        if (i_rst_gate) begin
            div_ctr_q <= '0;
        end else if (div_ctr_q != '0) begin
            div_ctr_q <= div_ctr_q - 1'b1;
        end else begin
            div_ctr_q <= reload;
        end
    end

    // One-cycle pulse at zero
    assign o_tick = (div_ctr_q == '0);

endmodule

// ==== common/tdc_record_if.sv ====
// Record bus with valid/ready; the source holds valid and record until the transfer
`timescale 1ns/1ps

interface tdc_record_if;
    import tdc_pkg::*;

    // Record offered by the source
    logic        valid;
    // Sink can take it this cycle
    logic        ready;
    tdc_record_u record;

    // ====================
    // Views
    // ====================

    // Producer side
    modport src (
        output valid,
        output record,
        input  ready
    );

    // Consumer side
    modport dst (
        input  valid,
        input  record,
        output ready
    );

endinterface

// ==== common/tdc_pkg.sv ====
// Record types of the TDC; the byte view only matches the fields while TDC_CTR_W is 16
`include "tdc_settings.svh"

package tdc_pkg;

    // ====================
    // Channel identity
    // ====================

    // 0 selects channel A, 1 selects channel B
    typedef logic chan_id_t;

    localparam chan_id_t CHAN_A = 1'b0;
    localparam chan_id_t CHAN_B = 1'b1;

    // ====================
    // Record layout
    // ====================

    // Most significant field first, so the header byte leads on the wire
    typedef struct packed {
        chan_id_t              chan_id;
        // At least one meas edge in the window
        logic                  valid;
        // Header padding, always zero
        logic [5:0]            rsvd;
        logic [`TDC_CTR_W-1:0] period;
        logic [`TDC_CTR_W-1:0] first;
        logic [`TDC_CTR_W-1:0] last;
    } tdc_fields_t;

    // Same word seen as fields or as bytes
    // Byte index REC_BYTES-1 is the header, index 0 the low byte of last
    typedef union packed {
        tdc_fields_t                      f;
        logic [`TDC_REC_BYTES-1:0][7:0]   b;
    } tdc_record_u;

endpackage

// ==== common/tdc_settings.svh ====
// Compile-time sizes of the TDC. Counts must fit TDC_CTR_W and the record must stay 7 bytes
`ifndef TDC_SETTINGS_SVH
`define TDC_SETTINGS_SVH

// ====================
// Counters
// ====================

// Width of period, first and last counts
`define TDC_CTR_W 16

// ====================
// Gate divider
// ====================

// Nominal gate period in clk_gate cycles
`define TDC_DIV_GATE 40
// Trim step applied by finc / fdec
`define TDC_DIV_DELTA 4

// ====================
// Record
// ====================

// Header byte plus three counts of two bytes each
`define TDC_REC_BYTES 7

`endif
